//--- mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Datapath word
	localparam int DATA_W = 32;
	// Register address, five bits for 32 registers
	localparam int REG_AW = 5;
	// Register count derived from the address width
	localparam int REG_N = 1 << REG_AW;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		ADDI  = 6'h08,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		LW    = 6'h23,
		SW    = 6'h2b
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		ADD = 6'h20,
		SUB = 6'h22,
		AND = 6'h24,
		OR  = 6'h25,
		SLT = 6'h2a
	} functT;

	////////////////////////////////////////////////////////////
	// Internal control codes
	////////////////////////////////////////////////////////////

	// ALU operation carried from decode to execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	// Operand source select; memory stage beats writeback
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwdSelT;

endpackage

//--- regFile.sv
`timescale 1ns/10ps

module regFile
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mipsPkg::REG_AW-1:0]  ra1,
	input  logic [mipsPkg::REG_AW-1:0]  ra2,
	output logic [mipsPkg::DATA_W-1:0]  rd1,
	output logic [mipsPkg::DATA_W-1:0]  rd2,
	input  logic                        we,
	input  logic [mipsPkg::REG_AW-1:0]  wa,
	input  logic [mipsPkg::DATA_W-1:0]  wd
);

	// Register storage
	logic [mipsPkg::DATA_W-1:0] regs [mipsPkg::REG_N];

	// One read port: r0 is hard zero, then write-through bypass
	function automatic logic [mipsPkg::DATA_W-1:0] readPort(
		input logic [mipsPkg::REG_AW-1:0] addr
	);
		if (addr == '0)
			return '0;
		else if (we && (wa == addr))
			return wd;
		else
			return regs[addr];
	endfunction

	// Write port, r0 never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < mipsPkg::REG_N; i++)
				regs[i] <= '0;
		end
		else if (we && (wa != '0))
			regs[wa] <= wd;
	end

	// Both read ports share the same logic
	always_comb
	begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

endmodule

//--- decodeStage.sv
`timescale 1ns/10ps

module decodeStage
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        instValid,
	input  logic [mipsPkg::DATA_W-1:0]  instr,
	// Register file read
	output logic [mipsPkg::REG_AW-1:0]  ra1,
	output logic [mipsPkg::REG_AW-1:0]  ra2,
	input  logic [mipsPkg::DATA_W-1:0]  rd1,
	input  logic [mipsPkg::DATA_W-1:0]  rd2,
	// Execute stage fields
	output logic                        validE,
	output mipsPkg::aluOpT              aluOpE,
	output logic                        aluSrcE,
	output logic                        regDstE,
	output logic                        memReadE,
	output logic                        memWriteE,
	output logic                        regWriteE,
	output logic [mipsPkg::DATA_W-1:0]  rd1E,
	output logic [mipsPkg::DATA_W-1:0]  rd2E,
	output logic [mipsPkg::REG_AW-1:0]  rsE,
	output logic [mipsPkg::REG_AW-1:0]  rtE,
	output logic [mipsPkg::REG_AW-1:0]  rdE,
	output logic [mipsPkg::DATA_W-1:0]  signImmE
);

	////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////

	mipsPkg::opcodeT            opcode;
	mipsPkg::functT             funct;
	logic [mipsPkg::REG_AW-1:0] rs;
	logic [mipsPkg::REG_AW-1:0] rt;
	logic [mipsPkg::REG_AW-1:0] rd;
	logic [15:0]                imm;

	assign opcode = mipsPkg::opcodeT'(instr[31:26]);
	assign funct  = mipsPkg::functT'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];

	// rs and rt go straight to the register file
	assign ra1 = rs;
	assign ra2 = rt;

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////

	mipsPkg::aluOpT              aluOp;
	logic                        aluSrc;
	logic                        regDst;
	logic                        memRead;
	logic                        memWrite;
	logic                        regWrite;
	logic                        zeroExt;
	logic [mipsPkg::DATA_W-1:0]  signImm;

	always_comb
	begin
		// Defaults: no side effects, add
		aluOp    = mipsPkg::ALU_ADD;
		aluSrc   = 1'b0;
		regDst   = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		zeroExt  = 1'b0;
		case (opcode)
			mipsPkg::RTYPE:
			begin
				regDst   = 1'b1;
				regWrite = 1'b1;
				case (funct)
					mipsPkg::ADD: aluOp = mipsPkg::ALU_ADD;
					mipsPkg::SUB: aluOp = mipsPkg::ALU_SUB;
					mipsPkg::AND: aluOp = mipsPkg::ALU_AND;
					mipsPkg::OR:  aluOp = mipsPkg::ALU_OR;
					mipsPkg::SLT: aluOp = mipsPkg::ALU_SLT;
					// unknown function acts as a no-op
					default:      regWrite = 1'b0;
				endcase
			end
			mipsPkg::ADDI:
			begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::ANDI:
			begin
				aluOp    = mipsPkg::ALU_AND;
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				zeroExt  = 1'b1;
			end
			mipsPkg::ORI:
			begin
				aluOp    = mipsPkg::ALU_OR;
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				zeroExt  = 1'b1;
			end
			mipsPkg::LW:
			begin
				aluSrc   = 1'b1;
				memRead  = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::SW:
			begin
				aluSrc   = 1'b1;
				memWrite = 1'b1;
			end
			default:
				aluOp = mipsPkg::ALU_ADD;
		endcase
	end

	// Logic ops take the immediate unsigned
	assign signImm = zeroExt ? {{(mipsPkg::DATA_W-16){1'b0}}, imm}
	                         : {{(mipsPkg::DATA_W-16){imm[15]}}, imm};

	////////////////////////////////////////////////////////////
	// Decode to execute register
	////////////////////////////////////////////////////////////

	// Control bits, qualified by the strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			validE    <= 1'b0;
			aluOpE    <= mipsPkg::ALU_ADD;
			aluSrcE   <= 1'b0;
			regDstE   <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
			regWriteE <= 1'b0;
		end
		else
		begin
			validE    <= instValid;
			aluOpE    <= aluOp;
			aluSrcE   <= aluSrc;
			regDstE   <= regDst;
			memReadE  <= instValid & memRead;
			memWriteE <= instValid & memWrite;
			regWriteE <= instValid & regWrite;
		end
	end

	// Operands and register numbers
	always_ff @(posedge clk)
	begin
		rd1E     <= rd1;
		rd2E     <= rd2;
		rsE      <= rs;
		rtE      <= rt;
		rdE      <= rd;
		signImmE <= signImm;
	end

endmodule

//--- forwardUnit.sv
`timescale 1ns/10ps

module forwardUnit
(
	input  logic [mipsPkg::REG_AW-1:0]  rsE,
	input  logic [mipsPkg::REG_AW-1:0]  rtE,
	input  logic                        regWriteM,
	input  logic [mipsPkg::REG_AW-1:0]  writeRegM,
	input  logic                        regWriteW,
	input  logic [mipsPkg::REG_AW-1:0]  writeRegW,
	output mipsPkg::fwdSelT             forwardAE,
	output mipsPkg::fwdSelT             forwardBE
);

	// Hazard check for one source register
	function automatic mipsPkg::fwdSelT fwdSel(
		input logic [mipsPkg::REG_AW-1:0] src
	);
		// r0 is constant, never forwarded
		if (src == '0)
			return mipsPkg::FWD_REG;
		// Youngest producer first
		else if (regWriteM && (writeRegM == src))
			return mipsPkg::FWD_MEM;
		else if (regWriteW && (writeRegW == src))
			return mipsPkg::FWD_WB;
		else
			return mipsPkg::FWD_REG;
	endfunction

	// Same rule on both operands
	always_comb
	begin
		forwardAE = fwdSel(rsE);
		forwardBE = fwdSel(rtE);
	end

endmodule

//--- execStage.sv
`timescale 1ns/10ps

module execStage
(
	input  logic                        clk,
	input  logic                        rst,
	// Execute stage fields
	input  logic                        validE,
	input  mipsPkg::aluOpT              aluOpE,
	input  logic                        aluSrcE,
	input  logic                        regDstE,
	input  logic                        memReadE,
	input  logic                        memWriteE,
	input  logic                        regWriteE,
	input  logic [mipsPkg::DATA_W-1:0]  rd1E,
	input  logic [mipsPkg::DATA_W-1:0]  rd2E,
	input  logic [mipsPkg::REG_AW-1:0]  rtE,
	input  logic [mipsPkg::REG_AW-1:0]  rdE,
	input  logic [mipsPkg::DATA_W-1:0]  signImmE,
	// Writeback value for forwarding
	input  logic [mipsPkg::DATA_W-1:0]  resultW,
	input  mipsPkg::fwdSelT             forwardAE,
	input  mipsPkg::fwdSelT             forwardBE,
	// Memory stage fields
	output logic                        validM,
	output logic                        memReadM,
	output logic                        memWriteM,
	output logic                        regWriteM,
	output logic [mipsPkg::DATA_W-1:0]  aluOutM,
	output logic [mipsPkg::DATA_W-1:0]  writeDataM,
	output logic [mipsPkg::REG_AW-1:0]  writeRegM
);

	logic [mipsPkg::DATA_W-1:0] srcAE;
	logic [mipsPkg::DATA_W-1:0] writeDataE;
	logic [mipsPkg::DATA_W-1:0] srcBE;
	logic [mipsPkg::DATA_W-1:0] aluOutE;
	logic [mipsPkg::REG_AW-1:0] writeRegE;
	logic                       lessThan;

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////

	// Register value, or a newer one still in flight
	function automatic logic [mipsPkg::DATA_W-1:0] fwdMux(
		input mipsPkg::fwdSelT            sel,
		input logic [mipsPkg::DATA_W-1:0] regVal
	);
		case (sel)
			mipsPkg::FWD_MEM: return aluOutM;
			mipsPkg::FWD_WB:  return resultW;
			default:          return regVal;
		endcase
	endfunction

	always_comb
	begin
		srcAE      = fwdMux(forwardAE, rd1E);
		// Forwarded rt is also the store data
		writeDataE = fwdMux(forwardBE, rd2E);
	end

	// Immediate replaces operand B
	assign srcBE = aluSrcE ? signImmE : writeDataE;

	// R-type writes rd, immediate forms write rt
	assign writeRegE = regDstE ? rdE : rtE;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	// Signed compare for slt
	assign lessThan = $signed(srcAE) < $signed(srcBE);

	always_comb
	begin
		case (aluOpE)
			mipsPkg::ALU_ADD: aluOutE = srcAE + srcBE;
			mipsPkg::ALU_SUB: aluOutE = srcAE - srcBE;
			mipsPkg::ALU_AND: aluOutE = srcAE & srcBE;
			mipsPkg::ALU_OR:  aluOutE = srcAE | srcBE;
			mipsPkg::ALU_SLT: aluOutE = {{(mipsPkg::DATA_W-1){1'b0}}, lessThan};
			default:          aluOutE = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Execute to memory register
	////////////////////////////////////////////////////////////

	// Control, dropped for bubbles
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			validM    <= 1'b0;
			memReadM  <= 1'b0;
			memWriteM <= 1'b0;
			regWriteM <= 1'b0;
		end
		else
		begin
			validM    <= validE;
			memReadM  <= validE & memReadE;
			memWriteM <= validE & memWriteE;
			regWriteM <= validE & regWriteE;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		aluOutM    <= aluOutE;
		writeDataM <= writeDataE;
		writeRegM  <= writeRegE;
	end

endmodule

//--- memStage.sv
`timescale 1ns/10ps

module memStage
#(
	parameter int dmemWords = 64
)
(
	input  logic                        clk,
	input  logic                        rst,
	// Memory stage fields
	input  logic                        validM,
	input  logic                        memReadM,
	input  logic                        memWriteM,
	input  logic                        regWriteM,
	input  logic [mipsPkg::DATA_W-1:0]  aluOutM,
	input  logic [mipsPkg::DATA_W-1:0]  writeDataM,
	input  logic [mipsPkg::REG_AW-1:0]  writeRegM,
	// Writeback fields
	output logic                        regWriteW,
	output logic [mipsPkg::REG_AW-1:0]  writeRegW,
	output logic [mipsPkg::DATA_W-1:0]  resultW
);

	// Word index width, at least one bit
	localparam int idxW = (dmemWords > 1) ? $clog2(dmemWords) : 1;

	logic [mipsPkg::DATA_W-1:0] dmem [dmemWords];
	logic [idxW-1:0]            wordIdx;
	logic [mipsPkg::DATA_W-1:0] loadData;

	////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////

	// Word address wraps at the depth
	assign wordIdx = aluOutM[idxW-1:0];

	// Store on a valid sw only
	always_ff @(posedge clk)
	begin
		if (validM && memWriteM)
			dmem[wordIdx] <= writeDataM;
	end

	// Asynchronous read
	assign loadData = dmem[wordIdx];

	////////////////////////////////////////////////////////////
	// Memory to writeback register
	////////////////////////////////////////////////////////////

	// Writes to r0 retire silently
	always_ff @(posedge clk)
	begin
		if (rst)
			regWriteW <= 1'b0;
		else
			regWriteW <= validM & regWriteM & (writeRegM != '0);
	end

	// Load data or ALU result
	always_ff @(posedge clk)
	begin
		writeRegW <= writeRegM;
		resultW   <= memReadM ? loadData : aluOutM;
	end

endmodule

//--- mipsPipe.sv
`timescale 1ns/10ps

module mipsPipe
#(
	parameter int dmemWords = 64
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        instValid,
	input  logic [mipsPkg::DATA_W-1:0]  instr,
	// Retiring register write
	output logic                        wbValid,
	output logic [mipsPkg::REG_AW-1:0]  wbReg,
	output logic [mipsPkg::DATA_W-1:0]  wbData
);

	// Register file read
	logic [mipsPkg::REG_AW-1:0] ra1;
	logic [mipsPkg::REG_AW-1:0] ra2;
	logic [mipsPkg::DATA_W-1:0] rd1;
	logic [mipsPkg::DATA_W-1:0] rd2;

	// Execute stage
	logic                       validE;
	mipsPkg::aluOpT             aluOpE;
	logic                       aluSrcE;
	logic                       regDstE;
	logic                       memReadE;
	logic                       memWriteE;
	logic                       regWriteE;
	logic [mipsPkg::DATA_W-1:0] rd1E;
	logic [mipsPkg::DATA_W-1:0] rd2E;
	logic [mipsPkg::REG_AW-1:0] rsE;
	logic [mipsPkg::REG_AW-1:0] rtE;
	logic [mipsPkg::REG_AW-1:0] rdE;
	logic [mipsPkg::DATA_W-1:0] signImmE;
	mipsPkg::fwdSelT            forwardAE;
	mipsPkg::fwdSelT            forwardBE;

	// Memory stage
	logic                       validM;
	logic                       memReadM;
	logic                       memWriteM;
	logic                       regWriteM;
	logic [mipsPkg::DATA_W-1:0] aluOutM;
	logic [mipsPkg::DATA_W-1:0] writeDataM;
	logic [mipsPkg::REG_AW-1:0] writeRegM;

	////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////

	// Writeback fields double as the top-level outputs
	regFile uRegFile (
		.clk (clk),
		.rst (rst),
		.ra1 (ra1),
		.ra2 (ra2),
		.rd1 (rd1),
		.rd2 (rd2),
		.we  (wbValid),
		.wa  (wbReg),
		.wd  (wbData)
	);

	decodeStage uDecode (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.instr     (instr),
		.ra1       (ra1),
		.ra2       (ra2),
		.rd1       (rd1),
		.rd2       (rd2),
		.validE    (validE),
		.aluOpE    (aluOpE),
		.aluSrcE   (aluSrcE),
		.regDstE   (regDstE),
		.memReadE  (memReadE),
		.memWriteE (memWriteE),
		.regWriteE (regWriteE),
		.rd1E      (rd1E),
		.rd2E      (rd2E),
		.rsE       (rsE),
		.rtE       (rtE),
		.rdE       (rdE),
		.signImmE  (signImmE)
	);

	forwardUnit uForward (
		.rsE       (rsE),
		.rtE       (rtE),
		.regWriteM (regWriteM),
		.writeRegM (writeRegM),
		.regWriteW (wbValid),
		.writeRegW (wbReg),
		.forwardAE (forwardAE),
		.forwardBE (forwardBE)
	);

	execStage uExec (
		.clk        (clk),
		.rst        (rst),
		.validE     (validE),
		.aluOpE     (aluOpE),
		.aluSrcE    (aluSrcE),
		.regDstE    (regDstE),
		.memReadE   (memReadE),
		.memWriteE  (memWriteE),
		.regWriteE  (regWriteE),
		.rd1E       (rd1E),
		.rd2E       (rd2E),
		.rtE        (rtE),
		.rdE        (rdE),
		.signImmE   (signImmE),
		.resultW    (wbData),
		.forwardAE  (forwardAE),
		.forwardBE  (forwardBE),
		.validM     (validM),
		.memReadM   (memReadM),
		.memWriteM  (memWriteM),
		.regWriteM  (regWriteM),
		.aluOutM    (aluOutM),
		.writeDataM (writeDataM),
		.writeRegM  (writeRegM)
	);

	memStage #(
		.dmemWords (dmemWords)
	) uMem (
		.clk        (clk),
		.rst        (rst),
		.validM     (validM),
		.memReadM   (memReadM),
		.memWriteM  (memWriteM),
		.regWriteM  (regWriteM),
		.aluOutM    (aluOutM),
		.writeDataM (writeDataM),
		.writeRegM  (writeRegM),
		.regWriteW  (wbValid),
		.writeRegW  (wbReg),
		.resultW    (wbData)
	);

endmodule

//--- tbChecker.sv
`timescale 1ns/10ps

module tbChecker
#(
	parameter int dmemWords = 64
)
(
	input  logic                        clk,
	input  logic                        rst,
	// Issue side of the DUT
	input  logic                        instValid,
	input  logic [mipsPkg::DATA_W-1:0]  instr,
	// Retire side of the DUT
	input  logic                        wbValid,
	input  logic [mipsPkg::REG_AW-1:0]  wbReg,
	input  logic [mipsPkg::DATA_W-1:0]  wbData,
	// Test boundary from the stimulus side
	input  logic                        testEnd,
	input  logic [3:0]                  testNum,
	output int                          checkCount,
	output int                          errorCount
);

	// Reference architectural state
	logic [mipsPkg::DATA_W-1:0] refRegs [mipsPkg::REG_N];
	logic [mipsPkg::DATA_W-1:0] refMem [dmemWords];

	// Writebacks still owed by the DUT, oldest first
	logic [mipsPkg::REG_AW-1:0] expReg [$];
	logic [mipsPkg::DATA_W-1:0] expVal [$];

	int chkCnt = 0;
	int errCnt = 0;
	int testChecks = 0;
	int testErrors = 0;
	int resetEdges = 0;

	assign checkCount = chkCnt;
	assign errorCount = errCnt;

	task automatic noteError();
		errCnt++;
		testErrors++;
	endtask

	////////////////////////////////////////////////////////////
	// Instruction-level reference model
	////////////////////////////////////////////////////////////

	task automatic modelExec(input logic [mipsPkg::DATA_W-1:0] word);
		logic [mipsPkg::REG_AW-1:0] rs;
		logic [mipsPkg::REG_AW-1:0] rt;
		logic [mipsPkg::REG_AW-1:0] dest;
		logic [mipsPkg::DATA_W-1:0] a;
		logic [mipsPkg::DATA_W-1:0] b;
		logic [mipsPkg::DATA_W-1:0] sImm;
		logic [mipsPkg::DATA_W-1:0] zImm;
		logic [mipsPkg::DATA_W-1:0] res;
		logic                       writes;
		int                         idx;
		rs   = word[25:21];
		rt   = word[20:16];
		a    = refRegs[rs];
		b    = refRegs[rt];
		sImm = {{16{word[15]}}, word[15:0]};
		zImm = {16'h0000, word[15:0]};
		// Word index wraps at the memory depth
		idx    = int'((a + sImm) % 32'(dmemWords));
		writes = 1'b1;
		dest   = rt;
		res    = '0;
		case (mipsPkg::opcodeT'(word[31:26]))
			mipsPkg::RTYPE:
			begin
				dest = word[15:11];
				case (mipsPkg::functT'(word[5:0]))
					mipsPkg::ADD: res = a + b;
					mipsPkg::SUB: res = a - b;
					mipsPkg::AND: res = a & b;
					mipsPkg::OR:  res = a | b;
					// Two's complement compare
					mipsPkg::SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:      writes = 1'b0;
				endcase
			end
			mipsPkg::ADDI: res = a + sImm;
			mipsPkg::ANDI: res = a & zImm;
			mipsPkg::ORI:  res = a | zImm;
			mipsPkg::LW:   res = refMem[idx];
			mipsPkg::SW:
			begin
				refMem[idx] = b;
				writes      = 1'b0;
			end
			default:       writes = 1'b0;
		endcase
		// r0 stays zero and retires silently
		if (writes && (dest != '0))
		begin
			refRegs[dest] = res;
			expReg.push_back(dest);
			expVal.push_back(res);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Comparison and reporting
	////////////////////////////////////////////////////////////

	task automatic compareWb();
		logic [mipsPkg::REG_AW-1:0] r;
		logic [mipsPkg::DATA_W-1:0] v;
		if (expReg.size() == 0)
		begin
			$display("Unexpected writeback to r%0d at %0t with nothing outstanding",
			         wbReg, $time);
			noteError();
		end
		else
		begin
			r = expReg.pop_front();
			v = expVal.pop_front();
			chkCnt++;
			testChecks++;
			if (wbReg !== r)
			begin
				$display("[ERROR] %0t wbReg expected %0d actual %0d", $time, r, wbReg);
				noteError();
			end
			if (wbData !== v)
			begin
				$display("[ERROR] %0t wbData expected %h actual %h", $time, v, wbData);
				noteError();
			end
		end
	endtask

	// Anything still queued here never retired
	task automatic finishTest();
		if (expReg.size() != 0)
		begin
			$display("Test %0d ended with %0d expected writebacks missing",
			         testNum, expReg.size());
			noteError();
			expReg.delete();
			expVal.delete();
		end
		$display("Test %0d done: %0d writebacks checked, %0d errors, %s",
		         testNum, testChecks, testErrors, (testErrors == 0) ? "PASS" : "FAIL");
		testChecks = 0;
		testErrors = 0;
	endtask

	// Inputs and outputs sampled at the edge, before the DUT updates
	always @(posedge clk)
	begin
		if (rst)
		begin
			// First edge still sees power-up X
			if ((resetEdges > 0) && (wbValid !== 1'b0))
			begin
				$display("wbValid was not low during reset at %0t", $time);
				noteError();
			end
			resetEdges++;
			for (int i = 0; i < mipsPkg::REG_N; i++)
				refRegs[i] = '0;
			expReg.delete();
			expVal.delete();
		end
		else
		begin
			if (wbValid === 1'b1)
				compareWb();
			else if (wbValid !== 1'b0)
			begin
				$display("wbValid is unknown at %0t", $time);
				noteError();
			end
			if (instValid === 1'b1)
				modelExec(instr);
			if (testEnd === 1'b1)
				finishTest();
		end
	end

endmodule

//--- tbMipsPipe.sv
`timescale 1ns/10ps

module tbMipsPipe;

	localparam int dmemWords   = 64;
	localparam int resetCycles = 4;
	// Three-stage latency plus settling
	localparam int drainCycles = 5;

	// Test sizes in instructions or groups
	localparam int nZero    = 8;
	localparam int nAlu     = 24;
	localparam int nDist1   = 10;
	localparam int nDist23  = 12;
	localparam int nMem     = 12;
	localparam int nRegZero = 8;
	localparam int numTests = 6;

	// Upper bound on issued instructions
	// Each one takes at most seven cycles
	localparam int maxInstr = nZero + (mipsPkg::REG_N - 1) + nAlu + 2 * nDist1
	                        + 3 * nDist23 + 3 * nMem + 2 * nRegZero;
	localparam int cycleLimit = resetCycles + 7 * maxInstr
	                          + numTests * (2 * drainCycles + 2) + 100;

	logic                       clk;
	logic                       rst;
	logic                       instValid;
	logic [mipsPkg::DATA_W-1:0] instr;
	logic                       wbValid;
	logic [mipsPkg::REG_AW-1:0] wbReg;
	logic [mipsPkg::DATA_W-1:0] wbData;
	logic                       testEnd;
	logic [3:0]                 testNum;
	int                         checkCount;
	int                         errorCount;
	int                         cycleCount;
	integer                     seed;

	// Word addresses written by the memory test
	logic [15:0] storedAddr [nMem];

	mipsPipe #(
		.dmemWords (dmemWords)
	) uut (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.instr     (instr),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData)
	);

	tbChecker #(
		.dmemWords (dmemWords)
	) chk (
		.clk        (clk),
		.rst        (rst),
		.instValid  (instValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData),
		.testEnd    (testEnd),
		.testNum    (testNum),
		.checkCount (checkCount),
		.errorCount (errorCount)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Random picks and encoders
	////////////////////////////////////////////////////////////

	function automatic int randRange(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	function automatic logic [mipsPkg::REG_AW-1:0] pickReg(input int lo);
		return 5'(randRange(lo, mipsPkg::REG_N - 1));
	endfunction

	function automatic mipsPkg::functT pickFunct();
		case (randRange(0, 4))
			0:       return mipsPkg::ADD;
			1:       return mipsPkg::SUB;
			2:       return mipsPkg::AND;
			3:       return mipsPkg::OR;
			default: return mipsPkg::SLT;
		endcase
	endfunction

	function automatic logic [31:0] encodeR(
		input mipsPkg::functT             fn,
		input logic [mipsPkg::REG_AW-1:0] rs,
		input logic [mipsPkg::REG_AW-1:0] rt,
		input logic [mipsPkg::REG_AW-1:0] rd
	);
		return {mipsPkg::RTYPE, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic logic [31:0] encodeI(
		input mipsPkg::opcodeT            op,
		input logic [mipsPkg::REG_AW-1:0] rs,
		input logic [mipsPkg::REG_AW-1:0] rt,
		input logic [15:0]                imm
	);
		return {op, rs, rt, imm};
	endfunction

	////////////////////////////////////////////////////////////
	// Drive helpers called just after a rising edge
	////////////////////////////////////////////////////////////

	// One-cycle strobe
	task automatic issue(input logic [31:0] word);
		instValid <= 1'b1;
		instr     <= word;
		@(posedge clk);
		instValid <= 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Drain then let the checker close out the test
	task automatic closeTest(input int n);
		idleCycles(drainCycles);
		testNum <= 4'(n);
		testEnd <= 1'b1;
		@(posedge clk);
		testEnd <= 1'b0;
		@(posedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic resetZeroTest();
		// Quiet stretch with no writeback allowed
		idleCycles(3);
		for (int i = 0; i < nZero; i++)
			issue(encodeR(mipsPkg::ADD, pickReg(0), pickReg(0), pickReg(1)));
		closeTest(1);
	endtask

	task automatic independentAluTest();
		logic [15:0] imm;
		// Signed 16-bit preload of r1..r31
		for (int r = 1; r < mipsPkg::REG_N; r++)
		begin
			imm = 16'(randRange(0, 65535));
			issue(encodeI(mipsPkg::ADDI, 5'd0, 5'(r), imm));
		end
		idleCycles(drainCycles);
		for (int i = 0; i < nAlu; i++)
		begin
			issue(encodeR(pickFunct(), pickReg(0), pickReg(0), pickReg(1)));
			// Gap keeps every source in the register file
			idleCycles(randRange(3, 6));
		end
		closeTest(2);
	endtask

	task automatic forwardNearTest();
		logic [mipsPkg::REG_AW-1:0] p;
		logic [mipsPkg::REG_AW-1:0] other;
		for (int g = 0; g < nDist1; g++)
		begin
			p = pickReg(1);
			issue(encodeR(pickFunct(), pickReg(0), pickReg(0), p));
			other = pickReg(0);
			// Consumer right behind on A, B or both
			case (g % 3)
				0:       issue(encodeR(pickFunct(), p, other, pickReg(1)));
				1:       issue(encodeR(pickFunct(), other, p, pickReg(1)));
				default: issue(encodeR(pickFunct(), p, p, pickReg(1)));
			endcase
			idleCycles(randRange(0, 1));
		end
		closeTest(3);
	endtask

	task automatic forwardFarTest();
		logic [mipsPkg::REG_AW-1:0] p;
		logic [15:0]                imm;
		mipsPkg::opcodeT            op;
		for (int g = 0; g < nDist23; g++)
		begin
			p   = pickReg(1);
			imm = 16'(randRange(0, 65535));
			// Odd groups set the top bit so sign or zero extension shows
			if (g % 2 == 1)
				imm = imm | 16'h8000;
			case (g % 3)
				0:       op = mipsPkg::ADDI;
				1:       op = mipsPkg::ANDI;
				default: op = mipsPkg::ORI;
			endcase
			issue(encodeI(op, pickReg(0), p, imm));
			// Distance two via writeback and three via bypass
			idleCycles(1 + (g / 2) % 2);
			if (randRange(0, 1) == 0)
				issue(encodeR(pickFunct(), p, pickReg(0), pickReg(1)));
			else
				issue(encodeR(pickFunct(), pickReg(0), p, pickReg(1)));
		end
		closeTest(4);
	endtask

	task automatic memoryTest();
		logic [mipsPkg::REG_AW-1:0] d;
		for (int i = 0; i < nMem; i++)
		begin
			storedAddr[i] = 16'(randRange(0, dmemWords - 1));
			issue(encodeI(mipsPkg::SW, 5'd0, pickReg(1), storedAddr[i]));
		end
		for (int i = 0; i < nMem; i++)
		begin
			d = pickReg(1);
			issue(encodeI(mipsPkg::LW, 5'd0, d, storedAddr[randRange(0, nMem - 1)]));
			// Load-use rule keeps the slot after the load empty
			idleCycles(randRange(1, 2));
			if (i % 2 == 0)
				issue(encodeR(mipsPkg::ADD, d, pickReg(0), pickReg(1)));
			else
				issue(encodeR(pickFunct(), pickReg(0), d, pickReg(1)));
		end
		closeTest(5);
	endtask

	task automatic regZeroTest();
		for (int g = 0; g < nRegZero; g++)
		begin
			// Writes aimed at r0 are all discarded
			case (g % 4)
				0:       issue(encodeR(pickFunct(), pickReg(0), pickReg(0), 5'd0));
				1:       issue(encodeI(mipsPkg::ADDI, pickReg(0), 5'd0,
				                       16'(randRange(1, 65535))));
				2:       issue(encodeI(mipsPkg::ORI, pickReg(0), 5'd0,
				                       16'(randRange(1, 65535))));
				default:
				begin
					issue(encodeI(mipsPkg::LW, 5'd0, 5'd0, storedAddr[randRange(0, nMem - 1)]));
					idleCycles(1);
				end
			endcase
			// r0 read right behind must not be forwarded
			if (g % 2 == 0)
				issue(encodeR(pickFunct(), 5'd0, 5'd0, pickReg(1)));
			else
				issue(encodeI(mipsPkg::ORI, 5'd0, pickReg(1), 16'(randRange(0, 65535))));
		end
		closeTest(6);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence and timeout
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h828a_c115;
		clk  = 1'b0;
		rst       <= 1'b1;
		instValid <= 1'b0;
		instr     <= '0;
		testEnd   <= 1'b0;
		testNum   <= '0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		resetZeroTest();
		independentAluTest();
		forwardNearTest();
		forwardFarTest();
		memoryTest();
		regZeroTest();
		// Counts settle away from the checker's edge
		@(negedge clk);
		$display("Summary: %0d tests, %0d writebacks checked, %0d errors",
		         numTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Run bound from the test sizes above
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- mipsPipe.f
mipsPkg.sv
regFile.sv
decodeStage.sv
forwardUnit.sv
execStage.sv
memStage.sv
mipsPipe.sv
tbChecker.sv
tbMipsPipe.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

# Compile the whole file list into one executable
verilator --binary --timing --top-module tbMipsPipe -f mipsPipe.f -o simMipsPipe
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

# Run, keeping the output for the pass/fail search
./obj_dir/simMipsPipe > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "CHECKS FAILED" "$logFile"; then
	echo "Result: FAIL"
	exit 1
fi

echo "Result: PASS"
exit 0
